//--- rtl/cnn_fixed_pkg.sv
package cnn_fixed_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Q6.10 sample format
	////////////////////////////////////////////////////////////////////////////
	localparam int FIX_W     = 16;        // word width of one sample
	localparam int FRAC_BITS = 10;        // binary point position
	localparam int PROD_W    = 2 * FIX_W; // full product width

	typedef logic signed [FIX_W-1:0]  fix16_t; // one Q6.10 value
	typedef logic signed [PROD_W-1:0] prod_t;  // Q12.20 product
	typedef logic signed [FIX_W:0]    sum17_t; // one guard bit for the bias add

	localparam fix16_t FIX_MAX = 16'sh7fff; // +31.999
	localparam fix16_t FIX_MIN = 16'sh8000; // -32.0

	// back to Q6.10, bits 25..10, upper bits just fall off
	function automatic fix16_t renorm(prod_t p);
		return p[FRAC_BITS+FIX_W-1:FRAC_BITS];
	endfunction

	// clamp a 17 bit sum, overflow shows as sign and guard bit disagreeing
	function automatic fix16_t sat17(sum17_t v);
		if (v[FIX_W] != v[FIX_W-1])
			return v[FIX_W] ? FIX_MIN : FIX_MAX;
		return v[FIX_W-1:0];
	endfunction

	function automatic fix16_t relu(fix16_t v);
		return v[FIX_W-1] ? fix16_t'(0) : v; // negatives go to zero
	endfunction

	function automatic fix16_t fix_max(fix16_t a, fix16_t b);
		return (a > b) ? a : b; // signed compare
	endfunction

endpackage

//--- rtl/cnn_layer_pkg.sv
package cnn_layer_pkg;

	////////////////////////////////////////////////////////////////////////////
	// layer 1 geometry
	////////////////////////////////////////////////////////////////////////////
	localparam int IN_CHANNELS = 3; // R, G, B
	localparam int PIX_W       = IN_CHANNELS * cnn_fixed_pkg::FIX_W; // 48
	localparam int WSEL_W      = 4; // 2*NUM_FILTERS addresses, up to 8 filters
	localparam int POOL_SIZE   = 2; // horizontal pooling window

	// R sits in the top word, B in the bottom word
	typedef logic [PIX_W-1:0]  pixel_t;
	typedef logic [PIX_W-1:0]  tap_vec_t; // same order as pixel_t
	typedef logic [WSEL_W-1:0] wsel_t;    // taps at 0..N-1, biases at N..2N-1

	// bit offset of channel ch inside a pixel or tap vector
	function automatic int ch_lsb(int ch);
		return (IN_CHANNELS - 1 - ch) * cnn_fixed_pkg::FIX_W;
	endfunction

endpackage

//--- rtl/layer1_weight_bank.sv
module layer1_weight_bank #(
	parameter int NUM_FILTERS = 8
) (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          wr_en,   // one cycle write strobe
	input  cnn_layer_pkg::wsel_t                          wr_sel,  // register address
	input  cnn_layer_pkg::tap_vec_t                       wr_data, // bias uses low word
	output cnn_layer_pkg::tap_vec_t [NUM_FILTERS-1:0]     taps,    // to stage 1
	output cnn_fixed_pkg::fix16_t   [NUM_FILTERS-1:0]     biases   // to stage 2
);
	import cnn_fixed_pkg::*;
	import cnn_layer_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////
	logic [NUM_FILTERS-1:0] tap_we;  // one hot per filter
	logic [NUM_FILTERS-1:0] bias_we;

	// addresses past 2*NUM_FILTERS-1 hit nothing
	always_comb
	begin
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			tap_we[f]  = wr_en && (wr_sel == wsel_t'(f));
			bias_we[f] = wr_en && (wr_sel == wsel_t'(NUM_FILTERS + f));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// tap and bias registers
	////////////////////////////////////////////////////////////////////////////
	// the new value lands on the strobe edge, stages see it next cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			taps   <= '0; // all filters start at zero weight
			biases <= '0;
		end
		else
		begin
			for (int f = 0; f < NUM_FILTERS; f++)
			begin
				if (tap_we[f])
					taps[f] <= wr_data; // all three taps at once
				if (bias_we[f])
					biases[f] <= fix16_t'(wr_data[FIX_W-1:0]);
			end
		end
	end

endmodule

//--- rtl/layer1_systolic.sv
module layer1_systolic #(
	parameter int NUM_FILTERS = 8
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      pix_valid,     // one beat per pixel
	input  logic                                      pix_row_start, // first pixel of a row
	input  cnn_layer_pkg::pixel_t                     pix_data,
	input  cnn_layer_pkg::tap_vec_t [NUM_FILTERS-1:0] taps,
	output logic                                      acc_valid,
	output logic                                      acc_row_start,
	output cnn_fixed_pkg::fix16_t   [NUM_FILTERS-1:0] acc_data
);
	import cnn_fixed_pkg::*;
	import cnn_layer_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// 1x1 convolution, three taps per filter
	////////////////////////////////////////////////////////////////////////////
	prod_t                   prod_c [NUM_FILTERS][IN_CHANNELS]; // full products
	fix16_t [NUM_FILTERS-1:0] sum_c;                            // wrapped tap sum

	always_comb
	begin
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			sum_c[f] = '0;
			for (int c = 0; c < IN_CHANNELS; c++)
			begin
				// signed 16x16, both operands sign extended into 32 bits
				prod_c[f][c] = fix16_t'(taps[f][ch_lsb(c) +: FIX_W])
					* fix16_t'(pix_data[ch_lsb(c) +: FIX_W]);
				// truncate first, then add, 16 bit overflow wraps
				sum_c[f] = sum_c[f] + renorm(prod_c[f][c]);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 1 register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			acc_valid     <= 1'b0;
			acc_row_start <= 1'b0;
		end
		else
		begin
			acc_valid     <= pix_valid;
			acc_row_start <= pix_valid && pix_row_start; // only meaningful with a beat
		end
	end

	// payload, held between beats
	always_ff @(posedge clk)
	begin
		if (pix_valid)
			acc_data <= sum_c;
	end

endmodule

//--- rtl/layer1_bias_relu.sv
module layer1_bias_relu #(
	parameter int NUM_FILTERS = 8
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    acc_valid,
	input  logic                                    acc_row_start,
	input  cnn_fixed_pkg::fix16_t [NUM_FILTERS-1:0] acc_data,
	input  cnn_fixed_pkg::fix16_t [NUM_FILTERS-1:0] biases,
	output logic                                    act_valid,
	output logic                                    act_row_start,
	output cnn_fixed_pkg::fix16_t [NUM_FILTERS-1:0] act_data
);
	import cnn_fixed_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// bias, clamp, ReLU
	////////////////////////////////////////////////////////////////////////////
	sum17_t                   biased_c [NUM_FILTERS]; // 17 bits, cannot overflow
	fix16_t [NUM_FILTERS-1:0] act_c;

	always_comb
	begin
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			biased_c[f] = sum17_t'($signed(acc_data[f])) + sum17_t'($signed(biases[f]));
			act_c[f]    = relu(sat17(biased_c[f])); // clamp, then drop negatives
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 2 register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			act_valid     <= 1'b0;
			act_row_start <= 1'b0;
		end
		else
		begin
			act_valid     <= acc_valid;
			act_row_start <= acc_valid && acc_row_start;
		end
	end

	always_ff @(posedge clk)
	begin
		if (acc_valid)
			act_data <= act_c; // one result per filter
	end

endmodule

//--- rtl/layer1_max_pool.sv
module layer1_max_pool #(
	parameter int NUM_FILTERS = 8
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    act_valid,
	input  logic                                    act_row_start, // forces a new pair
	input  cnn_fixed_pkg::fix16_t [NUM_FILTERS-1:0] act_data,
	output logic                                    feat_valid,    // one per full window
	output cnn_fixed_pkg::fix16_t [NUM_FILTERS-1:0] feat_data      // filter 0 in low word
);
	import cnn_fixed_pkg::*;
	import cnn_layer_pkg::*;

	localparam int CNT_W = $clog2(POOL_SIZE); // 1 bit for pairs

	////////////////////////////////////////////////////////////////////////////
	// window position
	////////////////////////////////////////////////////////////////////////////
	logic [CNT_W-1:0]         pool_cnt;   // beats already in the window, 0 = first
	logic                     first_beat; // opens a window
	logic                     last_beat;  // closes a window
	fix16_t [NUM_FILTERS-1:0] hold_q;     // running max of the window so far
	fix16_t [NUM_FILTERS-1:0] max_c;

	// a row start always opens a new window, a half filled one is dropped
	assign first_beat = act_valid && (act_row_start || (pool_cnt == '0));
	assign last_beat  = act_valid && !first_beat && (pool_cnt == CNT_W'(POOL_SIZE - 1));

	always_comb
	begin
		for (int f = 0; f < NUM_FILTERS; f++)
			max_c[f] = fix_max(hold_q[f], act_data[f]); // per filter, signed
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pool_cnt   <= '0; // expect the first of a pair
			feat_valid <= 1'b0;
		end
		else
		begin
			feat_valid <= last_beat; // one cycle after the closing beat
			if (first_beat)
				pool_cnt <= CNT_W'(1);
			else if (last_beat)
				pool_cnt <= '0;
			else if (act_valid)
				pool_cnt <= pool_cnt + CNT_W'(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (first_beat)
			hold_q <= act_data;  // start the window
		else if (act_valid)
			hold_q <= max_c;     // only reached for windows wider than 2
		if (last_beat)
			feat_data <= max_c;
	end

endmodule

//--- rtl/layer1_top.sv
module layer1_top #(
	parameter int NUM_FILTERS = 8 // at most 8, limited by wsel_t
) (
	input  logic                                    clk,
	input  logic                                    rst_n,
	// weight and bias load
	input  logic                                    wr_en,
	input  cnn_layer_pkg::wsel_t                    wr_sel,
	input  cnn_layer_pkg::tap_vec_t                 wr_data,
	// pixel stream, no back-pressure
	input  logic                                    pix_valid,
	input  cnn_layer_pkg::pixel_t                   pix_data,
	input  logic                                    pix_row_start,
	// pooled features, 3 cycles after the second pixel of a pair
	output logic                                    feat_valid,
	output cnn_fixed_pkg::fix16_t [NUM_FILTERS-1:0] feat_data
);
	import cnn_fixed_pkg::*;
	import cnn_layer_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// internal wiring
	////////////////////////////////////////////////////////////////////////////
	tap_vec_t [NUM_FILTERS-1:0] taps;    // bank -> stage 1
	fix16_t   [NUM_FILTERS-1:0] biases;  // bank -> stage 2

	logic                       acc_valid;     // stage 1 -> stage 2
	logic                       acc_row_start;
	fix16_t   [NUM_FILTERS-1:0] acc_data;

	logic                       act_valid;     // stage 2 -> stage 3
	logic                       act_row_start;
	fix16_t   [NUM_FILTERS-1:0] act_data;

	////////////////////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////////////////////
	layer1_weight_bank #(
		.NUM_FILTERS (NUM_FILTERS)
	) u_weight_bank (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_sel  (wr_sel),
		.wr_data (wr_data),
		.taps    (taps),
		.biases  (biases)
	);

	// stage 1, multiply-accumulate
	layer1_systolic #(
		.NUM_FILTERS (NUM_FILTERS)
	) u_systolic (
		.clk           (clk),
		.rst_n         (rst_n),
		.pix_valid     (pix_valid),
		.pix_row_start (pix_row_start),
		.pix_data      (pix_data),
		.taps          (taps),
		.acc_valid     (acc_valid),
		.acc_row_start (acc_row_start),
		.acc_data      (acc_data)
	);

	// stage 2, bias and activation
	layer1_bias_relu #(
		.NUM_FILTERS (NUM_FILTERS)
	) u_bias_relu (
		.clk           (clk),
		.rst_n         (rst_n),
		.acc_valid     (acc_valid),
		.acc_row_start (acc_row_start),
		.acc_data      (acc_data),
		.biases        (biases),
		.act_valid     (act_valid),
		.act_row_start (act_row_start),
		.act_data      (act_data)
	);

	// stage 3, pooling
	layer1_max_pool #(
		.NUM_FILTERS (NUM_FILTERS)
	) u_max_pool (
		.clk           (clk),
		.rst_n         (rst_n),
		.act_valid     (act_valid),
		.act_row_start (act_row_start),
		.act_data      (act_data),
		.feat_valid    (feat_valid),
		.feat_data     (feat_data)
	);

endmodule

//--- include/layer1_tb_model.svh
`ifndef LAYER1_TB_MODEL_SVH
`define LAYER1_TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// reference model, one filter at a time
////////////////////////////////////////////////////////////////////////////
// three taps, truncate each product to bits 25..10, 16 bit wrapping sum
function automatic cnn_fixed_pkg::fix16_t model_conv(cnn_layer_pkg::tap_vec_t t,
		cnn_layer_pkg::pixel_t p);
	cnn_fixed_pkg::fix16_t acc;
	cnn_fixed_pkg::prod_t  pr;
	acc = '0;
	for (int c = 0; c < 3; c++)
	begin
		pr  = $signed(t[c*16 +: 16]) * $signed(p[c*16 +: 16]);
		acc = acc + pr[25:10];
	end
	return acc;
endfunction

// bias add in 17 bits, clamp, ReLU
function automatic cnn_fixed_pkg::fix16_t model_act(cnn_fixed_pkg::fix16_t acc,
		cnn_fixed_pkg::fix16_t bias);
	logic signed [16:0] s;
	s = acc + bias;
	if (s > 17'sd32767)
		return 16'sh7fff;
	if (s < 0)
		return '0; // clamped or not, negatives end up at zero
	return s[15:0];
endfunction

function automatic cnn_fixed_pkg::fix16_t model_pair_max(cnn_fixed_pkg::fix16_t a,
		cnn_fixed_pkg::fix16_t b);
	return (a > b) ? a : b;
endfunction

////////////////////////////////////////////////////////////////////////////
// directed entries, same taps and bias on every filter
////////////////////////////////////////////////////////////////////////////
localparam int N_DIR     = 4;
localparam int MAX_PIX   = 8;
localparam int MAX_FEAT  = MAX_PIX / 2;
localparam int N_RAND    = 3;    // random entries after the directed ones
localparam int RAND_SEED = 8127;

// identity on R, fractional and large taps, positive bias, negative bias
localparam cnn_layer_pkg::tap_vec_t DIR_TAPS [N_DIR] = '{48'h0400_0000_0000,
	48'h0200_4000_FC00, 48'h0400_0000_0000, 48'h0400_0000_0000};
localparam cnn_fixed_pkg::fix16_t DIR_BIAS [N_DIR] = '{16'h0000, 16'h0000, 16'h7000, 16'hFC18};
localparam int DIR_LEN [N_DIR] = '{4, 4, 4, 7};
localparam logic [MAX_PIX-1:0] DIR_RS [N_DIR] = '{8'h01, 8'h01, 8'h01, 8'h29}; // bit i = pixel i

localparam cnn_layer_pkg::pixel_t DIR_PIX [N_DIR][MAX_PIX] = '{
	'{48'h0064_0200_0300, 48'h012C_0100_7000, 48'hFFCE_0050_0050, 48'hFFEC_0400_0400,
		48'h0, 48'h0, 48'h0, 48'h0},
	'{48'h03E8_0064_FF38, 48'hF830_0834_03E8, 48'hFFFD_0000_0005, 48'h0007_0001_0000,
		48'h0, 48'h0, 48'h0, 48'h0},
	'{48'h4E20_0000_0000, 48'h2710_0000_0000, 48'h8AD0_0000_0000, 48'h0064_0000_0000,
		48'h0, 48'h0, 48'h0, 48'h0},
	'{48'h05DC_1234_0000, 48'h0898_0000_0000, 48'h2328_0000_0000, 48'h01F4_0000_0000,
		48'h0FA0_0000_0000, 48'h8300_0000_0000, 48'h8000_0000_0000, 48'h0}};

localparam int DIR_NEXP [N_DIR] = '{2, 2, 2, 3};
localparam cnn_fixed_pkg::fix16_t DIR_EXP [N_DIR][MAX_FEAT] = '{
	'{16'sd300, 16'sd0, 16'sd0, 16'sd0},
	'{16'sd31600, 16'sd19, 16'sd0, 16'sd0},     // wrapped sum, then truncated fraction
	'{16'sd32767, 16'sd28772, 16'sd0, 16'sd0},  // clamp, then plain sum
	'{16'sd1200, 16'sd3000, 16'sd0, 16'sd0}};   // odd row drops 9000

`endif

//--- testbench/layer1_tb.sv
module layer1_tb;
	timeunit 1ns;
	timeprecision 10ps;

	import cnn_fixed_pkg::*;
	import cnn_layer_pkg::*;

	`include "layer1_tb_model.svh"

	localparam int NUM_FILTERS = 8;
	localparam int N_TESTS     = 1 + N_DIR + N_RAND; // reset state, directed, random
	localparam int CLK_NS      = 4;

	////////////////////////////////////////////////////////////////////////////
	// DUT and clock
	////////////////////////////////////////////////////////////////////////////
	logic                     clk;
	logic                     rst_n;
	logic                     wr_en;
	wsel_t                    wr_sel;
	tap_vec_t                 wr_data;
	logic                     pix_valid;
	pixel_t                   pix_data;
	logic                     pix_row_start;
	logic                     feat_valid;
	fix16_t [NUM_FILTERS-1:0] feat_data;

	layer1_top #(
		.NUM_FILTERS (NUM_FILTERS)
	) dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.wr_en         (wr_en),
		.wr_sel        (wr_sel),
		.wr_data       (wr_data),
		.pix_valid     (pix_valid),
		.pix_data      (pix_data),
		.pix_row_start (pix_row_start),
		.feat_valid    (feat_valid),
		.feat_data     (feat_data)
	);

	initial
		clk = 1'b0;
	always #(CLK_NS / 2) clk = ~clk;

	longint cyc = 0; // rising edges so far
	always @(posedge clk)
		cyc <= cyc + 1;

	////////////////////////////////////////////////////////////////////////////
	// test table, built once at time zero
	////////////////////////////////////////////////////////////////////////////
	tap_vec_t t_taps  [N_TESTS][NUM_FILTERS];
	fix16_t   t_bias  [N_TESTS][NUM_FILTERS];
	int       t_first [N_TESTS]; // first pixel of the test in the stream queues
	int       t_len   [N_TESTS];
	int       t_err   [N_TESTS];
	string    t_name  [N_TESTS];

	pixel_t s_pix [$];
	bit     s_rs  [$];
	int     s_gap [$]; // idle cycles after the pixel

	fix16_t [NUM_FILTERS-1:0] exp_feat [$]; // pending features, oldest first
	longint                   exp_due  [$]; // cycle the beat must show up
	int                       exp_test [$];

	int cur_test  = 0;
	int n_checked = 0;
	int watchdog_ns = 0;

	function automatic fix16_t rand_fix(int span);
		return fix16_t'(int'($urandom_range(2 * span - 1, 0)) - span); // -span .. span-1
	endfunction

	function automatic void add_pixel(pixel_t p, bit rs, int gap);
		s_pix.push_back(p);
		s_rs.push_back(rs);
		s_gap.push_back(gap);
	endfunction

	task automatic build_tests();
		int t;
		int len;
		// nothing loaded yet, so every feature is zero
		t_name[0]  = "reset state";
		t_first[0] = 0;
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			t_taps[0][f] = '0; // bank as it leaves reset
			t_bias[0][f] = '0;
		end
		add_pixel(48'h0400_1C00_8001, 1'b1, 0);
		add_pixel(48'h7FFF_0001_0400, 1'b0, 0);
		t_len[0] = 2;
		t_name[1] = "identity on R";
		t_name[2] = "renorm and wrap";
		t_name[3] = "bias saturation";
		t_name[4] = "relu and odd rows";
		for (int e = 0; e < N_DIR; e++)
		begin
			t          = 1 + e;
			t_first[t] = s_pix.size();
			t_len[t]   = DIR_LEN[e];
			for (int f = 0; f < NUM_FILTERS; f++)
			begin
				t_taps[t][f] = DIR_TAPS[e]; // same filter everywhere
				t_bias[t][f] = DIR_BIAS[e];
			end
			for (int i = 0; i < DIR_LEN[e]; i++)
				add_pixel(DIR_PIX[e][i], DIR_RS[e][i], 0); // back to back
		end
		for (int r = 0; r < N_RAND; r++)
		begin
			t          = 1 + N_DIR + r;
			t_name[t]  = $sformatf("random stream %0d", r);
			t_first[t] = s_pix.size();
			for (int f = 0; f < NUM_FILTERS; f++)
			begin
				t_taps[t][f] = {rand_fix(2048), rand_fix(2048), rand_fix(2048)}; // +-2.0
				t_bias[t][f] = rand_fix(4096);
			end
			for (int row = 0; row < 3; row++)
			begin
				len = $urandom_range(6, 1); // odd lengths drop a pixel
				for (int i = 0; i < len; i++)
					add_pixel(pixel_t'({$urandom(), $urandom()}), i == 0, $urandom_range(2, 0));
			end
			t_len[t] = s_pix.size() - t_first[t];
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////
	task automatic load_weights(int t);
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			@(posedge clk);
			wr_en   <= 1'b1;
			wr_sel  <= wsel_t'(f);
			wr_data <= t_taps[t][f];
			@(posedge clk);
			wr_sel  <= wsel_t'(NUM_FILTERS + f);
			wr_data <= {$urandom(), t_bias[t][f]}; // junk above the bias word
		end
	endtask

	task automatic run_test(int t);
		fix16_t [NUM_FILTERS-1:0] act;
		fix16_t [NUM_FILTERS-1:0] hold;   // first of the pair
		fix16_t [NUM_FILTERS-1:0] exp_v;
		bit                       pair_open;
		int                       n_pairs;
		int                       k;
		cur_test  = t;
		pair_open = 1'b0;
		n_pairs   = 0;
		if (t > 0)
			load_weights(t); // reset test runs on the cleared bank
		for (int i = 0; i < t_len[t]; i++)
		begin
			k = t_first[t] + i;
			@(posedge clk);
			wr_en         <= 1'b0;
			pix_valid     <= 1'b1;
			pix_data      <= s_pix[k];
			pix_row_start <= s_rs[k];
			for (int f = 0; f < NUM_FILTERS; f++)
				act[f] = model_act(model_conv(t_taps[t][f], s_pix[k]), t_bias[t][f]);
			if (s_rs[k] || !pair_open)
			begin
				hold      = act;  // row start always opens a pair
				pair_open = 1'b1;
			end
			else
			begin
				for (int f = 0; f < NUM_FILTERS; f++)
					exp_v[f] = model_pair_max(hold[f], act[f]);
				if (t >= 1 && t <= N_DIR && n_pairs < DIR_NEXP[t-1])
					for (int f = 0; f < NUM_FILTERS; f++)
						exp_v[f] = DIR_EXP[t-1][n_pairs]; // table value
				exp_feat.push_back(exp_v);
				exp_due.push_back(cyc + 4); // this edge is cyc+1, then 3 more
				exp_test.push_back(t);
				n_pairs++;
				pair_open = 1'b0;
			end
			repeat (s_gap[k])
			begin
				@(posedge clk);
				pix_valid <= 1'b0;
			end
		end
		@(posedge clk);
		pix_valid     <= 1'b0;
		pix_row_start <= 1'b0;
		if (t >= 1 && t <= N_DIR && n_pairs != DIR_NEXP[t-1])
		begin
			$display("test %0d: stream makes %0d pairs, table lists %0d", t, n_pairs,
				DIR_NEXP[t-1]);
			t_err[t]++;
		end
		while (exp_due.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk); // room for a stray late beat
		$display("test %0d %s: %s, %0d features", t, t_name[t],
			(t_err[t] == 0) ? "ok" : "failed", n_pairs);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// output monitor, samples on the falling edge
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			if (cyc > 0 && feat_valid)
			begin
				$display("feat_valid went high during reset at %t", $time);
				t_err[cur_test]++;
			end
		end
		else if (feat_valid)
		begin
			if (exp_due.size() == 0)
			begin
				$display("test %0d: extra feature beat at %t", cur_test, $time);
				t_err[cur_test]++;
			end
			else if (exp_due[0] > cyc)
			begin
				$display("test %0d: feature beat at %t is early", exp_test[0], $time);
				t_err[exp_test[0]]++;
			end
			else
			begin
				for (int f = 0; f < NUM_FILTERS; f++)
					if (feat_data[f] !== exp_feat[0][f])
					begin
						$display("Mismatch at %t: test %0d filter %0d got 0x%h, expected 0x%h",
							$time, exp_test[0], f, feat_data[f], exp_feat[0][f]);
						t_err[exp_test[0]]++;
					end
				n_checked++;
				void'(exp_feat.pop_front());
				void'(exp_due.pop_front());
				void'(exp_test.pop_front());
			end
		end
		else if (exp_due.size() != 0 && exp_due[0] <= cyc)
		begin
			$display("test %0d: feature beat due at %t never came", exp_test[0], $time);
			t_err[exp_test[0]]++;
			void'(exp_feat.pop_front());
			void'(exp_due.pop_front());
			void'(exp_test.pop_front());
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		int beats;
		int n_fail;
		int n_err;
		$timeformat(-9, 2, " ns", 0);
		rst_n         = 1'b0;
		wr_en         = 1'b0;
		wr_sel        = '0;
		wr_data       = '0;
		pix_valid     = 1'b0;
		pix_data      = '0;
		pix_row_start = 1'b0;
		void'($urandom(RAND_SEED));
		build_tests();
		beats = 10; // reset
		for (int t = 0; t < N_TESTS; t++)
		begin
			beats += 8 + ((t > 0) ? 2 * NUM_FILTERS : 0); // drain and weight load
			for (int i = 0; i < t_len[t]; i++)
				beats += 1 + s_gap[t_first[t] + i];
		end
		watchdog_ns = (beats + 20) * CLK_NS * 2;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		n_fail = 0;
		n_err  = 0;
		for (int t = 0; t < N_TESTS; t++)
		begin
			n_err += t_err[t];
			if (t_err[t] != 0)
				n_fail++;
		end
		$display("%0d tests, %0d failed, %0d features checked, %0d errors", N_TESTS, n_fail,
			n_checked, n_err);
		if (n_err == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("watchdog ran out after %0d ns, the run is stuck", watchdog_ns);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
rtl/cnn_fixed_pkg.sv
rtl/cnn_layer_pkg.sv
rtl/layer1_weight_bank.sv
rtl/layer1_systolic.sv
rtl/layer1_bias_relu.sv
rtl/layer1_max_pool.sv
rtl/layer1_top.sv
testbench/layer1_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the layer 1 testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timescale 1ns/10ps -Wno-fatal \
	-f src.f --top-module layer1_tb -o layer1_sim

./obj_dir/layer1_sim > sim.log 2>&1
cat sim.log

# the log decides pass or fail
if grep -qx "TEST PASS" sim.log
then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
